/* Makefile */
# Verilator build and run of the output port testbench

.PHONY: all lint clean

# Builds, runs, and passes only if the pass line shows up in the output
all:
	verilator --binary --timing --assert -Wno-fatal \
		-f vlog.f --top-module outputPort_tb -o simv
	./obj_dir/simv | tee /dev/stderr | grep -x '>>> PASS' > /dev/null

lint:
	verilator --lint-only --timing --assert -Wall \
		-f vlog.f --top-module outputPort_tb

clean:
	rm -rf obj_dir

/* flitSwitch.sv */
`default_nettype none

module flitSwitch
  import routerPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  portMaskT grant,
  input  logic     lValid,
  input  logic     nValid,
  input  logic     eValid,
  input  logic     wValid,
  input  logic     sValid,
  input  flitIdT   lFlitId,
  input  flitIdT   nFlitId,
  input  flitIdT   eFlitId,
  input  flitIdT   wFlitId,
  input  flitIdT   sFlitId,
  input  flitDataT lData,
  input  flitDataT nData,
  input  flitDataT eData,
  input  flitDataT wData,
  input  flitDataT sData,
  output logic     outValid,
  output flitIdT   outFlitId,
  output flitDataT outData
);

  portMaskT valids;
  logic     accept;
  flitIdT   selId;
  flitDataT selData;

  assign valids = {sValid, wValid, eValid, nValid, lValid};
  assign accept = |(valids & grant);   // Flits of other ports are dropped

  // Grant is one-hot so the OR of masked inputs is the selection
  assign selId = ({$bits(flitIdT){grant[0]}} & lFlitId) | ({$bits(flitIdT){grant[1]}} & nFlitId)
               | ({$bits(flitIdT){grant[2]}} & eFlitId) | ({$bits(flitIdT){grant[3]}} & wFlitId)
               | ({$bits(flitIdT){grant[4]}} & sFlitId);

  always_comb
  begin
    selData = '0;
    if (grant[0]) selData = lData;
    else if (grant[1]) selData = nData;
    else if (grant[2]) selData = eData;
    else if (grant[3]) selData = wData;
    else if (grant[4]) selData = sData;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= accept;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      outFlitId <= selId;
      outData   <= selData;
    end
  end

endmodule

`default_nettype wire

/* outputPort.sv */
`default_nettype none

module outputPort
  import routerPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     lReq,
  input  logic     nReq,
  input  logic     eReq,
  input  logic     wReq,
  input  logic     sReq,
  input  logic     lValid,
  input  logic     nValid,
  input  logic     eValid,
  input  logic     wValid,
  input  logic     sValid,
  input  flitIdT   lFlitId,
  input  flitIdT   nFlitId,
  input  flitIdT   eFlitId,
  input  flitIdT   wFlitId,
  input  flitIdT   sFlitId,
  input  pktLenT   lLength,
  input  pktLenT   nLength,
  input  pktLenT   eLength,
  input  pktLenT   wLength,
  input  pktLenT   sLength,
  input  flitDataT lData,
  input  flitDataT nData,
  input  flitDataT eData,
  input  flitDataT wData,
  input  flitDataT sData,
  output portMaskT grant,
  output logic     outValid,
  output flitDataT outData,
  output flitIdT   outFlitId
);

  // Grant goes to the switch and out of the port
  portArbiter arbiter (
    .clk(clk), .rst(rst),
    .lReq(lReq), .nReq(nReq), .eReq(eReq), .wReq(wReq), .sReq(sReq),
    .lValid(lValid), .nValid(nValid), .eValid(eValid), .wValid(wValid), .sValid(sValid),
    .lFlitId(lFlitId), .nFlitId(nFlitId), .eFlitId(eFlitId),
    .wFlitId(wFlitId), .sFlitId(sFlitId),
    .lLength(lLength), .nLength(nLength), .eLength(eLength),
    .wLength(wLength), .sLength(sLength),
    .grant(grant)
  );

  flitSwitch switch (
    .clk(clk), .rst(rst), .grant(grant),
    .lValid(lValid), .nValid(nValid), .eValid(eValid), .wValid(wValid), .sValid(sValid),
    .lFlitId(lFlitId), .nFlitId(nFlitId), .eFlitId(eFlitId),
    .wFlitId(wFlitId), .sFlitId(sFlitId),
    .lData(lData), .nData(nData), .eData(eData), .wData(wData), .sData(sData),
    .outValid(outValid), .outFlitId(outFlitId), .outData(outData)
  );

endmodule

`default_nettype wire

/* outputPort_assert.sv */
`default_nettype none

module outputPort_assert
  import routerPkg::*;
(
  input logic     clk,
  input logic     rst,
  input portMaskT grant,
  input logic     outValid
);

  // At most one port owns the output
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant %b is neither one-hot nor zero", grant);

  // A flit leaves only if some port held the grant a cycle earlier
  validNeedsGrant: assert property (
    @(posedge clk) disable iff (rst) outValid |-> ($past(grant) != '0)
  )
    else $error("outValid high without a grant in the previous cycle");

  grantClearAfterReset: assert property (@(posedge clk) rst |=> (grant == '0))
    else $error("grant %b not zero in the cycle after reset", grant);

endmodule

bind outputPort outputPort_assert grantChecks (
  .clk(clk),
  .rst(rst),
  .grant(grant),
  .outValid(outValid)
);

`default_nettype wire

/* outputPort_tb.sv */
`default_nettype none

`include "router_settings.svh"

module outputPort_tb
  import routerPkg::*;
();

  localparam int NumCycles = 3000;
  localparam int ClkPeriod = 20;
  localparam int ResetCycles = 4;
  localparam int NumPorts = `NUM_PORTS;

  logic     clk;
  logic     rst;
  portMaskT reqVec;
  portMaskT validVec;
  flitIdT   idVec [NumPorts];
  pktLenT   lenVec [NumPorts];
  flitDataT dataVec [NumPorts];

  portMaskT grant;
  logic     outValid;
  flitDataT outData;
  flitIdT   outFlitId;

  // Reference model, state 0 is idle and 1 to 5 grant L N E W S
  int       modelState;
  int       modelLimit [NumPorts];
  int       modelCount [NumPorts];
  logic     expValid;
  flitDataT expData;
  flitIdT   expId;

  logic [31:0] lcgState;
  int          runLeft [NumPorts];   // Cycles left in each request run
  int          grantsIssued;
  int          flitsForwarded;

  outputPort dut (
    .clk(clk), .rst(rst),
    .lReq(reqVec[0]), .nReq(reqVec[1]), .eReq(reqVec[2]), .wReq(reqVec[3]), .sReq(reqVec[4]),
    .lValid(validVec[0]), .nValid(validVec[1]), .eValid(validVec[2]),
    .wValid(validVec[3]), .sValid(validVec[4]),
    .lFlitId(idVec[0]), .nFlitId(idVec[1]), .eFlitId(idVec[2]),
    .wFlitId(idVec[3]), .sFlitId(idVec[4]),
    .lLength(lenVec[0]), .nLength(lenVec[1]), .eLength(lenVec[2]),
    .wLength(lenVec[3]), .sLength(lenVec[4]),
    .lData(dataVec[0]), .nData(dataVec[1]), .eData(dataVec[2]),
    .wData(dataVec[3]), .sData(dataVec[4]),
    .grant(grant), .outValid(outValid), .outData(outData), .outFlitId(outFlitId)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  function automatic logic [15:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[31:16];   // Upper bits, the low ones repeat quickly
  endfunction

  function automatic int randBelow(int n);
    return int'(nextRandom()) % n;
  endfunction

  // Scan from port "start" with wrap, returns 0 when nobody requests
  function automatic int firstRequester(portMaskT req, int start);
    int port;
    int found;
    found = 0;
    for (int k = 0; k < NumPorts; k++)
    begin
      port = (start + k) % NumPorts;
      if (found == 0 && req[port])
        found = port + 1;
    end
    return found;
  endfunction

  function automatic portMaskT grantOf(int st);
    portMaskT mask;
    mask = '0;
    if (st != 0)
      mask[st - 1] = 1'b1;
    return mask;
  endfunction

  task automatic failRun(string why);
    $display(">>> FAIL");
    $fatal(1, "%s", why);
  endtask

  task automatic driveInputs();
    for (int p = 0; p < NumPorts; p++)
    begin
      if (runLeft[p] == 0)
      begin
        reqVec[p] = (randBelow(2) != 0);
        runLeft[p] = 3 + randBelow(20);
      end
      else
        runLeft[p] = runLeft[p] - 1;
      validVec[p] = (randBelow(2) != 0);
      if (randBelow(3) == 0)
        idVec[p] = flitIdT'(`HEAD_FLIT_ID);
      else
        idVec[p] = flitIdT'(randBelow(8));   // Body flits also carry a length
      lenVec[p] = pktLenT'(randBelow(8));
      dataVec[p] = {nextRandom(), nextRandom()};
    end
  endtask

  // Advances the model by one clock with the inputs now driven
  task automatic stepModel();
    int       cur;
    int       nextState;
    portMaskT run;
    cur = 0;
    run = '0;
    expValid = 1'b0;
    if (modelState != 0)
    begin
      cur = modelState - 1;
      if (validVec[cur])
      begin
        expValid = 1'b1;
        expData = dataVec[cur];
        expId = idVec[cur];
        flitsForwarded++;
      end
    end

    if (modelState == 0)
      nextState = firstRequester(reqVec, 0);
    else if (reqVec[cur] && modelCount[cur] != modelLimit[cur])
    begin
      nextState = modelState;
      run[cur] = 1'b1;
    end
    else
      nextState = firstRequester(reqVec, cur + 1);

    for (int p = 0; p < NumPorts; p++)
    begin
      modelCount[p] = run[p] ? modelCount[p] + 1 : 0;
      if (validVec[p] && idVec[p] == flitIdT'(`HEAD_FLIT_ID))
        modelLimit[p] = int'(lenVec[p]);
    end
    if (nextState != 0 && nextState != modelState)
      grantsIssued++;
    modelState = nextState;
  endtask

  task automatic checkOutputs();
    portMaskT expGrant;
    expGrant = grantOf(modelState);
    assert (grant === expGrant)
    else
    begin
      $display("Mismatch at %0t: grant is %b, expected %b", $time, grant, expGrant);
      failRun("grant differs from the reference model");
    end
    assert (outValid === expValid)
    else
    begin
      $display("Mismatch at %0t: outValid is %b, expected %b", $time, outValid, expValid);
      failRun("outValid differs from the reference model");
    end
    if (expValid)
    begin
      assert (outData === expData)
      else
      begin
        $display("Mismatch at %0t: outData is %h, expected %h", $time, outData, expData);
        failRun("outData differs from the reference model");
      end
      assert (outFlitId === expId)
      else
      begin
        $display("Mismatch at %0t: outFlitId is %0d, expected %0d", $time, outFlitId, expId);
        failRun("outFlitId differs from the reference model");
      end
    end
  endtask

  // Watchdog
  initial
  begin
    #((ResetCycles + NumCycles + 50) * ClkPeriod);
    failRun("watchdog expired before the stimulus finished");
  end

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    lcgState = 32'd9488;
    reqVec = '0;
    validVec = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      idVec[p] = '0;
      lenVec[p] = '0;
      dataVec[p] = '0;
      runLeft[p] = 0;
      modelLimit[p] = 0;
      modelCount[p] = 0;
    end
    modelState = 0;
    expValid = 1'b0;
    expData = '0;
    expId = '0;
    grantsIssued = 0;
    flitsForwarded = 0;

    repeat (ResetCycles) @(negedge clk);
    rst = 1'b0;
    checkOutputs();   // Reset values

    for (int cycle = 0; cycle < NumCycles; cycle++)
    begin
      driveInputs();
      stepModel();
      @(negedge clk);
      checkOutputs();
    end

    $display("%0d cycles, %0d new grants, %0d flits forwarded",
             NumCycles, grantsIssued, flitsForwarded);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* portArbiter.sv */
`default_nettype none

module portArbiter
  import routerPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     lReq,
  input  logic     nReq,
  input  logic     eReq,
  input  logic     wReq,
  input  logic     sReq,
  input  logic     lValid,
  input  logic     nValid,
  input  logic     eValid,
  input  logic     wValid,
  input  logic     sValid,
  input  flitIdT   lFlitId,
  input  flitIdT   nFlitId,
  input  flitIdT   eFlitId,
  input  flitIdT   wFlitId,
  input  flitIdT   sFlitId,
  input  pktLenT   lLength,
  input  pktLenT   nLength,
  input  pktLenT   eLength,
  input  pktLenT   wLength,
  input  pktLenT   sLength,
  output portMaskT grant
);

  arbStateT   state;
  arbStateT   nextState;
  portMaskT   req;
  portMaskT   runTimer;
  portMaskT   timesUp;
  logic [2:0] curIdx;   // Port index of the granted state

  // First requester found when scanning from port "first" with wrap
  function automatic arbStateT pickNext(portMaskT requests, int unsigned first);
    arbStateT    pick;
    int unsigned idx;
    pick = IDLE;
    for (int i = $bits(portMaskT) - 1; i >= 0; i--)
    begin
      idx = (first + i) % $bits(portMaskT);
      if (requests[idx])
        pick = arbStateT'(idx + 1);
    end
    return pick;
  endfunction

  assign req = {sReq, wReq, eReq, nReq, lReq};
  assign curIdx = 3'(state) - 3'd1;

  tenureTimer lTimer (
    .clk(clk), .rst(rst), .valid(lValid), .flitId(lFlitId), .length(lLength),
    .runTimer(runTimer[0]), .timesUp(timesUp[0])
  );

  tenureTimer nTimer (
    .clk(clk), .rst(rst), .valid(nValid), .flitId(nFlitId), .length(nLength),
    .runTimer(runTimer[1]), .timesUp(timesUp[1])
  );

  tenureTimer eTimer (
    .clk(clk), .rst(rst), .valid(eValid), .flitId(eFlitId), .length(eLength),
    .runTimer(runTimer[2]), .timesUp(timesUp[2])
  );

  tenureTimer wTimer (
    .clk(clk), .rst(rst), .valid(wValid), .flitId(wFlitId), .length(wLength),
    .runTimer(runTimer[3]), .timesUp(timesUp[3])
  );

  tenureTimer sTimer (
    .clk(clk), .rst(rst), .valid(sValid), .flitId(sFlitId), .length(sLength),
    .runTimer(runTimer[4]), .timesUp(timesUp[4])
  );

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= nextState;
  end

  always_comb
  begin
    runTimer = '0;
    if (state == IDLE || state > GRANT_S)
      nextState = pickNext(req, 0);   // Fixed order L N E W S
    else if (req[curIdx] && !timesUp[curIdx])
    begin
      // Granted port stays, its timer keeps running
      nextState = state;
      runTimer[curIdx] = 1'b1;
    end
    else
      nextState = pickNext(req, int'(curIdx) + 1);   // Rotate past current port
  end

  always_comb
  begin
    grant = '0;
    if (state != IDLE && state <= GRANT_S)
      grant[curIdx] = 1'b1;
  end

endmodule

`default_nettype wire

/* routerPkg.sv */
`default_nettype none

`include "router_settings.svh"

package routerPkg;

  // Flit payload
  typedef logic [`FLIT_WIDTH-1:0] flitDataT;

  // Tenure limit, loaded from the packet length of a header flit
  typedef logic [`LEN_WIDTH-1:0] pktLenT;

  typedef logic [`FLIT_ID_WIDTH-1:0] flitIdT;

  // One bit per port, bit 0 is Local then North East West South
  typedef logic [`NUM_PORTS-1:0] portMaskT;

  // Arbiter states, GRANT_x holds the output for port x
  typedef enum logic [2:0]
  {
    IDLE,
    GRANT_L,
    GRANT_N,
    GRANT_E,
    GRANT_W,
    GRANT_S
  } arbStateT;

endpackage

`default_nettype wire

/* router_settings.svh */
`ifndef ROUTER_SETTINGS_SVH
`define ROUTER_SETTINGS_SVH

// Port count of the router, Local North East West South
`define NUM_PORTS 5

// Flit payload width
`define FLIT_WIDTH 32

// Packet length carried on a header flit
`define LEN_WIDTH 12

`define FLIT_ID_WIDTH 3

// Flit id value that marks a header flit
`define HEAD_FLIT_ID 1

`endif

/* tenureTimer.sv */
`default_nettype none

`include "router_settings.svh"

module tenureTimer
  import routerPkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   valid,
  input  flitIdT flitId,
  input  pktLenT length,
  input  logic   runTimer,
  output logic   timesUp
);

  pktLenT limit;
  pktLenT count;
  logic   headFlit;

  assign headFlit = valid && (flitId == flitIdT'(`HEAD_FLIT_ID));

  // Limit stays until the next header flit on this port
  always_ff @(posedge clk)
  begin
    if (rst)
      limit <= '0;
    else if (headFlit)
      limit <= length;
  end

  // Counts the cycles the port keeps the grant
  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (runTimer)
      count <= count + 1'b1;
    else
      count <= '0;   // Port not holding
  end

  assign timesUp = (count == limit);

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
routerPkg.sv
tenureTimer.sv
portArbiter.sv
flitSwitch.sv
outputPort.sv
outputPort_assert.sv
outputPort_tb.sv
